// ==== bench/cholesky_model.svh ====
// Integer reference of the fixed-point rules; inputs must keep every pivot positive and in range
`ifndef CHOLESKY_MODEL_SVH
`define CHOLESKY_MODEL_SVH

longint l_src [`CHOL_N][`CHOL_N]; // Factor that A is built from
longint a_mat [`CHOL_N][`CHOL_N]; // Matrix loaded into the DUT
longint exp_mat [`CHOL_N][`CHOL_N]; // Expected lower triangle, zero above

// Keeps the low WORD_W bits as a signed value, like a register of that width
function automatic longint wrap_word(longint v);
	longint m;
	m = v & ((longint'(1) << `CHOL_WORD_W) - 1);
	if (m >= (longint'(1) << (`CHOL_WORD_W - 1))) m = m - (longint'(1) << `CHOL_WORD_W);
	return m;
endfunction

// Largest r with r*r not above x, found one bit at a time from the top
function automatic longint floor_sqrt(longint x);
	longint r, t;
	int b;
	r = 0;
	for (b = 31; b >= 0; b--) begin
		t = r + (longint'(1) << b);
		if (t * t <= x) r = t; // Keep the bit when the square still fits
	end
	return r;
endfunction

// A = L times L transposed, each sum scaled back once by the fraction bits
function automatic void build_a_from_l();
	longint s;
	int r, c, m;
	for (r = 0; r < `CHOL_N; r++) begin
		for (c = 0; c <= r; c++) begin
			s = 0;
			for (m = 0; m <= c; m++) s = s + l_src[r][m] * l_src[c][m];
			a_mat[r][c] = s >>> `CHOL_FRAC_W;
			a_mat[c][r] = a_mat[r][c]; // Symmetric by construction
		end
	end
endfunction

// Right-looking factorization with the root, quotient and update rules
function automatic void decompose_model();
	int k, r, c;
	for (r = 0; r < `CHOL_N; r++)
		for (c = 0; c < `CHOL_N; c++) exp_mat[r][c] = (c <= r) ? a_mat[r][c] : 0;
	for (k = 0; k < `CHOL_N; k++) begin
		exp_mat[k][k] = wrap_word(floor_sqrt(exp_mat[k][k] <<< `CHOL_FRAC_W));
		for (r = k + 1; r < `CHOL_N; r++) // Longint division truncates toward zero
			exp_mat[r][k] = wrap_word((exp_mat[r][k] <<< `CHOL_FRAC_W) / exp_mat[k][k]);
		for (r = k + 1; r < `CHOL_N; r++)
			for (c = k + 1; c <= r; c++)
				exp_mat[r][c] = wrap_word(exp_mat[r][c] -
					((exp_mat[r][k] * exp_mat[c][k]) >>> `CHOL_FRAC_W));
	end
endfunction

`endif

// ==== bench/cholesky_tb.sv ====
// Directed tests for cholesky_top; the fixed factor table assumes CHOL_N of 4
`timescale 1ns/100ps
`default_nettype none

`include "cholesky_defines.svh"

module cholesky_tb import cholesky_pkg::*; ();

	localparam int N = `CHOL_N;
	localparam int F = `CHOL_FRAC_W;
	localparam int RUNS = 9; // Eight full runs and one cut short by reset
	localparam int LIMIT = 2 * RUNS * N * (`CHOL_SQRT_CYCLES + N * `CHOL_DIV_CYCLES + N * N + 8);

	logic i, reset, start, load_en, busy, done;
	idx_t load_row, load_col, read_row, read_col;
	word_t load_data, read_data;
	int errors;
	int cycles = 0;
	integer seed;

	`include "cholesky_model.svh"

	cholesky_top dut0 (
		.i(i), .reset(reset), .start(start), .load_en(load_en), .load_row(load_row),
		.load_col(load_col), .load_data(load_data), .read_row(read_row), .read_col(read_col),
		.read_data(read_data), .busy(busy), .done(done)
	);

	initial begin
		i = 1'b0;
		forever #50 i = ~i; // 100 ns period
	end

	always @(posedge i) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("timeout: the DUT did not finish within %0d cycles", LIMIT);
			$display("errors: %0d", errors);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	// Lower triangle first, then junk above it that the DUT must drop
	task automatic load_matrix();
		int r, c;
		for (r = 0; r < N; r++)
			for (c = 0; c <= r; c++) begin
				@(posedge i);
				load_en <= 1'b1;
				load_row <= idx_t'(r);
				load_col <= idx_t'(c);
				load_data <= word_t'(a_mat[r][c]);
			end
		// An accepted upper write would land on a lower slot and spoil the factor
		for (r = 0; r < N; r++)
			for (c = r + 1; c < N; c++) begin
				@(posedge i);
				load_en <= 1'b1;
				load_row <= idx_t'(r);
				load_col <= idx_t'(c);
				load_data <= word_t'('h5a5a5);
			end
		@(posedge i);
		load_en <= 1'b0;
	endtask

	task automatic pulse_start();
		@(posedge i);
		start <= 1'b1;
		@(posedge i);
		start <= 1'b0;
	endtask

	// Done must come with busy falling in the same cycle and last a single cycle
	task automatic wait_done(string name);
		logic was_busy;
		was_busy = 1'b0;
		@(negedge i);
		while (!done) begin
			was_busy = busy; // Busy level one cycle before done
			@(negedge i);
		end
		if (!was_busy) begin
			$display("%s: busy was already low in the cycle before done", name);
			errors++;
		end
		if (busy) begin
			$display("%s: busy was still high in the done cycle", name);
			errors++;
		end
		@(negedge i);
		if (done) begin
			$display("%s: done stayed high for more than one cycle", name);
			errors++;
		end
	endtask

	// Reads every entry, so each run also checks that the upper triangle reads zero
	task automatic compare_result(string name);
		int r, c;
		longint expected;
		for (r = 0; r < N; r++)
			for (c = 0; c < N; c++) begin
				@(posedge i);
				read_row <= idx_t'(r);
				read_col <= idx_t'(c);
				@(negedge i);
				expected = (c <= r) ? exp_mat[r][c] : 0;
				if (read_data !== word_t'(expected)) begin
					$display("mismatch %s (%0d,%0d): expected %0d, actual %0d", name, r, c,
						expected, read_data);
					errors++;
				end
			end
	endtask

	task automatic run_case(string name);
		load_matrix();
		pulse_start();
		wait_done(name);
		compare_result(name);
	endtask

	task automatic set_integer_factor();
		int tab [4][4] = '{'{2, 0, 0, 0}, '{1, 3, 0, 0}, '{-1, 2, 2, 0}, '{0, 1, -1, 1}};
		int r, c;
		for (r = 0; r < N; r++)
			for (c = 0; c < N; c++) l_src[r][c] = longint'(tab[r][c]) <<< F;
		build_a_from_l();
		decompose_model();
	endtask

	// Diagonal in [4, 8) and the rest in [-2, 2), which keeps A well conditioned
	task automatic set_random_factor();
		int r, c;
		for (r = 0; r < N; r++)
			for (c = 0; c < N; c++)
				if (c == r) l_src[r][c] = (longint'(4) << F) + longint'({$random(seed)} % (4 << F));
				else if (c < r) l_src[r][c] = longint'({$random(seed)} % (4 << F)) - (2 << F);
				else l_src[r][c] = 0;
		build_a_from_l();
		decompose_model();
	endtask

	task automatic test_identity();
		int r, c;
		for (r = 0; r < N; r++)
			for (c = 0; c < N; c++) begin
				a_mat[r][c] = (r == c) ? (longint'(1) << F) : 0; // One in fixed point
				exp_mat[r][c] = a_mat[r][c];
			end
		run_case("identity");
	endtask

	task automatic test_diagonal_squares();
		int r, c;
		for (r = 0; r < N; r++)
			for (c = 0; c < N; c++) begin
				a_mat[r][c] = (r == c) ? (longint'((r + 1) * (r + 1)) << F) : 0;
				exp_mat[r][c] = (r == c) ? (longint'(r + 1) << F) : 0; // Exact roots
			end
		run_case("diagonal squares");
	endtask

	task automatic test_random_factors(int count);
		int t;
		for (t = 0; t < count; t++) begin
			set_random_factor();
			run_case($sformatf("random %0d", t));
		end
	endtask

	// A second start and a load while busy must leave the run untouched
	task automatic test_protocol();
		int t;
		set_integer_factor();
		load_matrix();
		@(negedge i);
		if (busy) begin
			$display("protocol: busy was high before start");
			errors++;
		end
		pulse_start();
		@(negedge i);
		if (!busy) begin
			$display("protocol: busy did not rise after start");
			errors++;
		end
		@(posedge i);
		start <= 1'b1;
		load_en <= 1'b1;
		load_row <= idx_t'(N - 1);
		load_col <= idx_t'(N - 1);
		load_data <= word_t'('h1234);
		@(posedge i);
		start <= 1'b0;
		load_en <= 1'b0;
		wait_done("protocol");
		for (t = 0; t < 4; t++) begin
			@(negedge i);
			if (busy || done) begin
				$display("protocol: the start pulse seen while busy began another run");
				errors++;
			end
		end
		compare_result("protocol");
	endtask

	task automatic test_reset_mid_run();
		set_random_factor();
		load_matrix();
		pulse_start();
		repeat (40) @(posedge i); // Lands inside the first column's divisions
		reset <= 1'b1;
		repeat (3) @(posedge i);
		reset <= 1'b0;
		@(negedge i);
		if (busy || done) begin
			$display("reset mid run: busy or done still high after reset");
			errors++;
		end
		run_case("after reset");
	endtask

	initial begin
		seed = 70;
		errors = 0;
		reset = 1'b1;
		start = 1'b0;
		load_en = 1'b0;
		load_row = '0;
		load_col = '0;
		load_data = '0;
		read_row = '0;
		read_col = '0;
		repeat (3) @(posedge i);
		reset <= 1'b0;
		@(negedge i);
		if (busy || done) begin
			$display("busy or done was high right after reset");
			errors++;
		end
		test_identity();
		test_diagonal_squares();
		set_integer_factor();
		run_case("integer factor");
		test_random_factors(3);
		test_protocol();
		test_reset_mid_run();
		$display("errors: %0d", errors);
		if (errors == 0) $display("*** TEST PASSED ***");
		else $display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it, then looks for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module cholesky_tb -f sim.f -o cholesky_sim \
	> build.log 2>&1 &&
./obj_dir/cholesky_sim > sim.log 2>&1 ||
{ echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -qF "*** TEST PASSED ***" sim.log && echo "simulation passed" ||
{ echo "simulation failed, see sim.log"; exit 1; }

// ==== sim.f ====
+incdir+source
+incdir+bench
source/cholesky_pkg.sv
source/cholesky_control.sv
source/working_matrix.sv
source/sqrt_unit.sv
source/column_divider.sv
source/trailing_update.sv
source/cholesky_top.sv
bench/cholesky_tb.sv

// ==== source/cholesky_control.sv ====
// Start is ignored while busy; run length depends on CHOL_N and unit latencies, and nothing stalls
`timescale 1ns/100ps
`default_nettype none

`include "cholesky_defines.svh"

module cholesky_control import cholesky_pkg::*; (
	input logic i,
	input logic reset,
	input logic start,
	input logic root_done,
	input logic quot_done,
	output logic root_start,
	output logic div_start,
	output idx_t pivot,
	output idx_t row_sel,
	output idx_t col_sel,
	output logic upd_issue,
	output idx_t upd_row,
	output idx_t upd_col,
	output logic busy,
	output logic done
);

	localparam idx_t LAST = idx_t'(`CHOL_N - 1); // Index of the bottom row and right column

	phase_t phase; // Current phase of the column walk
	logic first; // High in the first cycle after entering a phase or a new row

	// A root or a division is issued once, on entry, and then waited on
	assign root_start = (phase == phase_root) && first;
	assign div_start = (phase == phase_divide) && first;
	assign upd_issue = (phase == phase_update); // One update leaves every cycle of this phase
	assign upd_row = row_sel; // The update target shares the factor row
	assign upd_col = col_sel; // and the second factor row
	assign busy = (phase != phase_idle); // Falls in the cycle where done is high

	always_ff @(posedge i) begin
		if (reset) begin
			phase <= phase_idle;
			first <= 1'b0;
			done <= 1'b0;
			pivot <= '0;
			row_sel <= '0;
			col_sel <= '0;
		end else begin
			done <= 1'b0; // Pulse only
			case (phase)
				phase_idle: begin
					if (start) begin
						phase <= phase_root; // Column zero starts right away
						first <= 1'b1;
						pivot <= '0;
					end
				end
				phase_root: begin
					first <= 1'b0;
					if (root_done) begin // Diagonal entry commits in this cycle
						if (pivot == LAST) begin
							phase <= phase_idle; // Nothing sits below the last pivot
							done <= 1'b1;
						end else begin
							phase <= phase_divide;
							first <= 1'b1;
							row_sel <= pivot + 1'b1; // First row under the pivot
						end
					end
				end
				phase_divide: begin
					first <= 1'b0;
					if (quot_done) begin // Quotient for row_sel commits in this cycle
						if (row_sel == LAST) begin
							phase <= phase_update;
							row_sel <= pivot + 1'b1; // Trailing block starts at its corner
							col_sel <= pivot + 1'b1;
						end else begin
							row_sel <= row_sel + 1'b1;
							first <= 1'b1; // Issue the next division
						end
					end
				end
				phase_update: begin
					if (col_sel == row_sel) begin // Reached the diagonal of this row
						if (row_sel == LAST) begin
							phase <= phase_drain;
							first <= 1'b1;
						end else begin
							row_sel <= row_sel + 1'b1;
							col_sel <= pivot + 1'b1;
						end
					end else begin
						col_sel <= col_sel + 1'b1;
					end
				end
				phase_drain: begin
					// The last update writes at the end of the second drain cycle
					first <= 1'b0;
					if (!first) begin
						phase <= phase_root;
						first <= 1'b1;
						pivot <= pivot + 1'b1; // Next root sees the updated pivot
					end
				end
				default: phase <= phase_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/cholesky_defines.svh ====
// Sizes and latencies shared by all units; CHOL_N must be at least 2 and WORD_W plus FRAC_W even
`ifndef CHOLESKY_DEFINES_SVH
`define CHOLESKY_DEFINES_SVH

// Matrix is CHOL_N by CHOL_N and only its lower triangle is kept
`define CHOL_N 4

// Signed fixed-point entries with CHOL_FRAC_W fraction bits
`define CHOL_WORD_W 24
`define CHOL_FRAC_W 8

// One root bit per cycle over the radical widened by the fraction bits
`define CHOL_SQRT_CYCLES ((`CHOL_WORD_W + `CHOL_FRAC_W) / 2)

// One quotient bit per cycle plus a final cycle that restores the sign
`define CHOL_DIV_CYCLES (`CHOL_WORD_W + `CHOL_FRAC_W + 1)

// Update pipeline depth from issue to array write
`define CHOL_UPD_CYCLES 2

// Quiet cycles after the last update of a column
`define CHOL_DRAIN_CYCLES 2

`endif

// ==== source/cholesky_pkg.sv ====
// Types only; widths follow the macros of cholesky_defines.svh and CHOL_N must be at least 2
`default_nettype none

`include "cholesky_defines.svh"

package cholesky_pkg;

	// One matrix entry in signed fixed point
	typedef logic signed [`CHOL_WORD_W-1:0] word_t;

	// Full product of two entries before it is scaled back
	typedef logic signed [2*`CHOL_WORD_W-1:0] wide_t;

	// Row or column number inside the matrix
	typedef logic [$clog2(`CHOL_N)-1:0] idx_t;

	// Where the column sequencer stands in the current column
	typedef enum logic [2:0] {
		phase_idle, // Waiting for start
		phase_root, // Square root of the pivot in flight
		phase_divide, // Scaling the entries below the pivot
		phase_update, // Issuing trailing-submatrix updates
		phase_drain // Letting the last updates land
	} phase_t;

endpackage

`default_nettype wire

// ==== source/cholesky_top.sv ====
// Input matrix must be symmetric positive definite; loads are ignored while busy and above the diagonal
`timescale 1ns/100ps
`default_nettype none

module cholesky_top import cholesky_pkg::*; (
	input logic i,
	input logic reset,
	input logic start,
	input logic load_en,
	input idx_t load_row,
	input idx_t load_col,
	input word_t load_data,
	input idx_t read_row,
	input idx_t read_col,
	output word_t read_data,
	output logic busy,
	output logic done
);

	logic root_start, root_done; // Square root handshake
	logic div_start, quot_done; // Divider handshake
	logic upd_issue, upd_wr_en; // Update pipeline entry and exit
	idx_t pivot, row_sel, col_sel; // Read addresses from the sequencer
	idx_t upd_row, upd_col, upd_wr_row, upd_wr_col; // Update target in and out of the pipeline
	word_t root, quotient, upd_wr_data; // Results written back into the array
	word_t pivot_data, row_data, col_data, target_data; // Operands read from the array

	cholesky_control control0 (
		.i(i), .reset(reset), .start(start), .root_done(root_done), .quot_done(quot_done),
		.root_start(root_start), .div_start(div_start), .pivot(pivot), .row_sel(row_sel),
		.col_sel(col_sel), .upd_issue(upd_issue), .upd_row(upd_row), .upd_col(upd_col),
		.busy(busy), .done(done)
	);

	working_matrix matrix0 (
		.i(i), .reset(reset), .load_en(load_en), .load_row(load_row), .load_col(load_col),
		.load_data(load_data), .busy(busy), .root_done(root_done), .pivot(pivot), .root(root),
		.quot_done(quot_done), .row_sel(row_sel), .quotient(quotient), .upd_wr_en(upd_wr_en),
		.upd_wr_row(upd_wr_row), .upd_wr_col(upd_wr_col), .upd_wr_data(upd_wr_data),
		.read_row(read_row), .read_col(read_col), .col_sel(col_sel), .upd_row(upd_row),
		.upd_col(upd_col), .read_data(read_data), .pivot_data(pivot_data),
		.row_data(row_data), .col_data(col_data), .target_data(target_data)
	);

	sqrt_unit sqrt0 (
		.i(i), .reset(reset), .root_start(root_start), .radical(pivot_data), .root(root),
		.root_done(root_done)
	);

	column_divider divider0 (
		.i(i), .reset(reset), .div_start(div_start), .dividend(row_data), .divisor(pivot_data),
		.quotient(quotient), .quot_done(quot_done)
	);

	trailing_update update0 (
		.i(i), .reset(reset), .upd_issue(upd_issue), .upd_row(upd_row), .upd_col(upd_col),
		.factor_a(row_data), .factor_b(col_data), .target(target_data), .upd_wr_en(upd_wr_en),
		.upd_wr_row(upd_wr_row), .upd_wr_col(upd_wr_col), .upd_wr_data(upd_wr_data)
	);

endmodule

`default_nettype wire

// ==== source/column_divider.sv ====
// Divisor must be nonzero; quotient truncates toward zero and keeps only the low WORD_W bits
`timescale 1ns/100ps
`default_nettype none

`include "cholesky_defines.svh"

module column_divider import cholesky_pkg::*; (
	input logic i,
	input logic reset,
	input logic div_start,
	input word_t dividend,
	input word_t divisor,
	output word_t quotient,
	output logic quot_done
);

	localparam int W = `CHOL_WORD_W;
	localparam int RW = `CHOL_WORD_W + `CHOL_FRAC_W; // Dividend widened by the fraction bits
	localparam int CW = $clog2(`CHOL_DIV_CYCLES);

	logic [W-1:0] mag_a, mag_b; // Operand magnitudes
	logic [RW-1:0] dq, src_dq, next_dq; // Dividend shifts out at the top, quotient in at the bottom
	logic [W-1:0] r, src_r, next_r, dv, src_dv; // Remainder and divisor magnitude
	logic [W:0] partial; // Remainder with the next dividend bit
	logic [W+1:0] diff; // Trial subtraction, sign in the top bit
	logic [CW-1:0] cnt; // Shift steps left after the current one
	logic active, neg, step, finish;

	assign mag_a = dividend[W-1] ? -dividend : dividend;
	assign mag_b = divisor[W-1] ? -divisor : divisor;
	assign step = div_start || (active && cnt != '0);
	assign finish = active && cnt == '0; // Sign restore cycle

	// The start cycle already does the first shift step
	always_comb begin
		src_dq = div_start ? {mag_a, {`CHOL_FRAC_W{1'b0}}} : dq;
		src_r = div_start ? '0 : r;
		src_dv = div_start ? mag_b : dv;
		partial = {src_r, src_dq[RW-1]};
		diff = {1'b0, partial} - {2'b00, src_dv};
		next_r = diff[W+1] ? partial[W-1:0] : diff[W-1:0]; // Keep the old remainder on borrow
		next_dq = {src_dq[RW-2:0], ~diff[W+1]};
	end

	always_ff @(posedge i) begin
		if (reset) begin
			active <= 1'b0;
			quot_done <= 1'b0;
			cnt <= '0;
		end else begin
			quot_done <= finish;
			if (div_start) begin
				active <= 1'b1;
				cnt <= CW'(`CHOL_DIV_CYCLES - 2); // Remaining shifts after this one
			end else if (step) begin
				cnt <= cnt - 1'b1;
			end else if (finish) begin
				active <= 1'b0;
			end
		end
	end

	always_ff @(posedge i) begin
		if (div_start) neg <= dividend[W-1] ^ divisor[W-1];
		if (step) begin
			dq <= next_dq;
			r <= next_r;
			dv <= src_dv;
		end
		if (finish) quotient <= neg ? word_t'(-dq[W-1:0]) : word_t'(dq[W-1:0]);
	end

	// A zero root would come from a singular or non-definite matrix
	divisor_nonzero: assert property (@(posedge i) disable iff (reset)
		div_start |-> divisor != '0)
		else $error("column_divider: zero divisor");

endmodule

`default_nettype wire

// ==== source/sqrt_unit.sv ====
// Radical must be non-negative; root is floor(sqrt(radical << FRAC_W)) and holds until the next start
`timescale 1ns/100ps
`default_nettype none

`include "cholesky_defines.svh"

module sqrt_unit import cholesky_pkg::*; (
	input logic i,
	input logic reset,
	input logic root_start,
	input word_t radical,
	output word_t root,
	output logic root_done
);

	localparam int RW = `CHOL_WORD_W + `CHOL_FRAC_W; // Widened radical
	localparam int HW = RW / 2; // Root bits
	localparam int CW = $clog2(`CHOL_SQRT_CYCLES);

	logic [RW-1:0] rad, src_rad; // Radical bits still to be consumed, two per step
	logic [HW:0] rem, src_rem, next_rem; // Partial remainder
	logic [HW-1:0] q, src_q, next_q; // Root bits found so far
	logic [HW+3:0] trial; // Remainder minus (4q + 1), sign in the top bit
	logic [CW-1:0] cnt; // Steps left after the current one
	logic active;

	// The first step runs in the start cycle straight from the input
	always_comb begin
		src_rad = root_start ? {radical, {`CHOL_FRAC_W{1'b0}}} : rad;
		src_rem = root_start ? '0 : rem;
		src_q = root_start ? '0 : q;
		trial = {1'b0, src_rem, src_rad[RW-1 -: 2]} - {2'b00, src_q, 2'b01};
		next_q = {src_q[HW-2:0], ~trial[HW+3]}; // New root bit is set when the trial fits
		if (!trial[HW+3]) next_rem = trial[HW:0];
		else next_rem = {src_rem[HW-2:0], src_rad[RW-1 -: 2]}; // Restore and bring in two bits
	end

	always_ff @(posedge i) begin
		if (reset) begin
			active <= 1'b0;
			root_done <= 1'b0;
			cnt <= '0;
		end else begin
			root_done <= 1'b0;
			if (root_start) begin
				active <= 1'b1;
				cnt <= CW'(`CHOL_SQRT_CYCLES - 1);
			end else if (active) begin
				cnt <= cnt - 1'b1;
				if (cnt == CW'(1)) begin // Last root bit lands at this edge
					active <= 1'b0;
					root_done <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge i) begin
		if (root_start || active) begin
			rad <= src_rad << 2;
			rem <= next_rem;
			q <= next_q;
		end
	end

	assign root = word_t'(q); // Zero extended since the root is never negative

	// A negative pivot means the loaded matrix was not positive definite
	radical_sign: assert property (@(posedge i) disable iff (reset)
		root_start |-> !radical[`CHOL_WORD_W-1])
		else $error("sqrt_unit: negative radical");

endmodule

`default_nettype wire

// ==== source/trailing_update.sv ====
// Accepts one issue per cycle and writes two cycles later; the scaled product is truncated to WORD_W
`timescale 1ns/100ps
`default_nettype none

`include "cholesky_defines.svh"

module trailing_update import cholesky_pkg::*; (
	input logic i,
	input logic reset,
	input logic upd_issue,
	input idx_t upd_row,
	input idx_t upd_col,
	input word_t factor_a,
	input word_t factor_b,
	input word_t target,
	output logic upd_wr_en,
	output idx_t upd_wr_row,
	output idx_t upd_wr_col,
	output word_t upd_wr_data
);

	logic stage_valid; // First stage holds a live update
	wide_t prod; // L(i,k) times L(j,k) at full width
	word_t stage_target; // A(i,j) captured at issue
	idx_t stage_row, stage_col;

	always_ff @(posedge i) begin
		if (reset) begin
			stage_valid <= 1'b0;
			upd_wr_en <= 1'b0;
		end else begin
			stage_valid <= upd_issue;
			upd_wr_en <= stage_valid; // Write strobe two cycles after issue
		end
	end

	always_ff @(posedge i) begin
		prod <= factor_a * factor_b;
		stage_target <= target;
		stage_row <= upd_row;
		stage_col <= upd_col;
		upd_wr_data <= stage_target - word_t'(prod >>> `CHOL_FRAC_W); // Back to CHOL_FRAC_W
		upd_wr_row <= stage_row;
		upd_wr_col <= stage_col;
	end

endmodule

`default_nettype wire

// ==== source/working_matrix.sv ====
// Entries above the diagonal read as zero; only one engine write per cycle and no loads while busy
`timescale 1ns/100ps
`default_nettype none

`include "cholesky_defines.svh"

module working_matrix import cholesky_pkg::*; (
	input logic i,
	input logic reset,
	input logic load_en,
	input idx_t load_row,
	input idx_t load_col,
	input word_t load_data,
	input logic busy,
	input logic root_done,
	input idx_t pivot,
	input word_t root,
	input logic quot_done,
	input idx_t row_sel,
	input word_t quotient,
	input logic upd_wr_en,
	input idx_t upd_wr_row,
	input idx_t upd_wr_col,
	input word_t upd_wr_data,
	input idx_t read_row,
	input idx_t read_col,
	input idx_t col_sel,
	input idx_t upd_row,
	input idx_t upd_col,
	output word_t read_data,
	output word_t pivot_data,
	output word_t row_data,
	output word_t col_data,
	output word_t target_data
);

	localparam int ENTRIES = `CHOL_N * (`CHOL_N + 1) / 2; // Lower triangle including the diagonal

	word_t mem [ENTRIES]; // Row r starts at slot r*(r+1)/2
	logic load_ok; // Accepted external write

	// Packs a lower-triangle position into a flat slot number
	function automatic int slot(idx_t r, idx_t c);
		return (int'(r) * (int'(r) + 1)) / 2 + int'(c);
	endfunction

	assign load_ok = load_en && !busy && !reset && (load_col <= load_row); // Upper entries dropped

	always_ff @(posedge i) begin
		if (load_ok) mem[slot(load_row, load_col)] <= load_data;
		if (root_done) mem[slot(pivot, pivot)] <= root; // L(k,k) replaces A(k,k)
		if (quot_done) mem[slot(row_sel, pivot)] <= quotient; // L(i,k) below the pivot
		if (upd_wr_en) mem[slot(upd_wr_row, upd_wr_col)] <= upd_wr_data; // Trailing block
	end

	// Reads go straight from the array, so a write shows up one cycle later
	always_comb begin
		read_data = (read_col <= read_row) ? mem[slot(read_row, read_col)] : '0;
		pivot_data = mem[slot(pivot, pivot)];
		row_data = (pivot <= row_sel) ? mem[slot(row_sel, pivot)] : '0;
		col_data = (pivot <= col_sel) ? mem[slot(col_sel, pivot)] : '0;
		target_data = (upd_col <= upd_row) ? mem[slot(upd_row, upd_col)] : '0;
	end

	// The sequencer keeps root, divide and update writes apart in time
	single_writer: assert property (@(posedge i) disable iff (reset)
		$onehot0({root_done, quot_done, upd_wr_en}))
		else $error("working_matrix: two engine writes in one cycle");

endmodule

`default_nettype wire
